/* all.f */
source/control_pkg.sv
source/opcode_decoder.sv
source/micro_sequencer.sv
source/control_word_encoder.sv
source/control_unit.sv
tb/control_unit_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the control unit testbench with Verilator and runs it.
set -u

cd "$(dirname "$0")" || exit 1

top=control_unit_tb
build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
        --top-module "$top" -Mdir "$build_dir" -f all.f
status=$?
if [ $status -ne 0 ]; then
        echo "verilator build failed with status $status"
        exit 1
fi

"./$build_dir/V$top" > "$log_file" 2>&1
status=$?
cat "$log_file"
if [ $status -ne 0 ]; then
        echo "simulation exited with status $status"
        exit 1
fi

if grep -q "FAIL: see errors above" "$log_file"; then
        exit 1
fi
exit 0

/* tb/control_unit_tb.sv */
module control_unit_tb
        import control_pkg::*;
();

        timeunit 1ns;
        timeprecision 1ps;

        localparam int reset_cycles = 8;
        localparam int endop_hold   = 10;

        // write-enable mask and read code for each operand register code.
        localparam logic [15:0] reg_write_mask [16] = '{
                16'h0000, 16'h0010, 16'h0020, 16'h0040, 16'h0080, 16'h0100, 16'h0200, 16'h0400,
                16'h0800, 16'h1000, 16'h2000, 16'h4000, 16'h0000, 16'h0000, 16'h0000, 16'h0000};
        localparam logic [4:0] reg_read_code [16] = '{
                5'd0, 5'd7, 5'd8, 5'd9, 5'd10, 5'd11, 5'd12, 5'd13,
                5'd14, 5'd15, 5'd16, 5'd17, 5'd0, 5'd0, 5'd0, 5'd0};

        logic          clk;
        logic          reset;
        logic [15:0]   instruction;
        logic          zero_flag;
        write_enable_t write_enable;
        read_sel_t     read_enable;
        increment_t    increment;
        alu_op_t       alu;
        logic          finish;

        logic [7:0]  row_op[$];
        logic [3:0]  row_operand[$];
        logic        row_z[$];
        string       row_name[$];
        state_t      chain[$];
        logic [31:0] lfsr;
        int          error_count;
        int          failed_tests;
        int          test_count;
        int          cycle_limit;
        int          cycle_count = 0;

        control_unit dut (
                .clk          (clk),
                .reset        (reset),
                .instruction  (instruction),
                .Z            (zero_flag),
                .write_enable (write_enable),
                .read_enable  (read_enable),
                .increment    (increment),
                .alu          (alu),
                .finish       (finish)
        );

        always #20 clk = ~clk;

        always @(posedge clk)
        begin
                cycle_count = cycle_count + 1;
                if (cycle_limit > 0 && cycle_count >= cycle_limit)
                begin
                        $display("timeout: the run did not finish within %0d cycles", cycle_limit);
                        $display("FAIL: see errors above");
                        $finish;
                end
        end

        // taps 32, 22, 2 and 1; the new bit enters at the bottom.
        function automatic logic [31:0] lfsr_next(input logic [31:0] s);
                return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
        endfunction

        task automatic random_operand(output logic [3:0] value);
                value = 4'd0;
                for (int i = 0; i < 4; i++)
                begin
                        lfsr  = lfsr_next(lfsr);
                        value = {value[2:0], lfsr[0]};
                end
        endtask

        function automatic logic [3:0] decode_operand(input logic [7:0] op,
                                                      input logic [3:0] field);
                logic [3:0] code;
                code = 4'd0;
                if (op == op_add)
                begin
                        case (field[1:0])
                                2'd1:    code = 4'd7;
                                2'd2:    code = 4'd8;
                                2'd3:    code = 4'd9;
                                default: code = 4'd0;
                        endcase
                end
                else if ((op == op_mvac || op == op_movreg) && field >= 4'd1 && field <= 4'd11)
                        code = field;
                return code;
        endfunction

        // packed as write enable, read select, increment, alu and finish.
        function automatic logic [28:0] expected_word(input state_t s, input logic [3:0] code);
                logic [15:0] we;
                logic [4:0]  rd;
                logic [3:0]  inc;
                logic [2:0]  alu_code;
                logic        fin;
                we       = 16'h0000;
                rd       = 5'd0;
                inc      = 4'b0000;
                alu_code = 3'd0;
                fin      = 1'b0;
                case (s)
                        fetch1, lodac1, jump1: rd = 5'd1;
                        fetch2, lodac2, jump2:
                        begin
                                we = 16'h0004;
                                rd = 5'd1;
                        end
                        fetch3, jumpzn, jmnzn: inc = 4'b0001;
                        add1:
                        begin
                                rd       = reg_read_code[code];
                                alu_code = 3'd1;
                        end
                        sub1:
                        begin
                                rd       = 5'd13;
                                alu_code = 3'd3;
                        end
                        clac1: alu_code = 3'd6;
                        sftr1: alu_code = 3'd4;
                        sftl1: alu_code = 3'd5;
                        add2, sub2, clac2, sftr2, sftl2: we = 16'h0001;
                        lodac3:
                        begin
                                we  = 16'h0008;
                                rd  = 5'd4;
                                inc = 4'b0001;
                        end
                        lodac4:
                        begin
                                we = 16'h4000;
                                rd = 5'd2;
                        end
                        lodac5:
                        begin
                                we = 16'h8000;
                                rd = 5'd17;
                        end
                        mvac:
                        begin
                                we = reg_write_mask[code];
                                rd = (code == 4'd0) ? 5'd0 : 5'd6;
                        end
                        movreg:
                        begin
                                rd = reg_read_code[code];
                                we = (code == 4'd0) ? 16'h0000 : 16'h8000;
                        end
                        jump3: we = 16'h0002;
                        incac: inc = 4'b0010;
                        incr:  inc = 4'b0100;
                        incr3: inc = 4'b1000;
                        endop: fin = 1'b1;
                        default: fin = 1'b0;
                endcase
                return {we, rd, inc, alu_code, fin};
        endfunction

        task automatic build_chain(input logic [7:0] op, input logic z);
                chain.delete();
                case (op)
                        op_add:    chain = '{add1, add2};
                        op_sub:    chain = '{sub1, sub2};
                        op_clac:   chain = '{clac1, clac2};
                        op_sftr:   chain = '{sftr1, sftr2};
                        op_sftl:   chain = '{sftl1, sftl2};
                        op_lodac:  chain = '{lodac1, lodac2, lodac3, lodac4, lodac5};
                        op_mvac:   chain = '{mvac};
                        op_movreg: chain = '{movreg};
                        op_incac:  chain = '{incac};
                        op_incr:   chain = '{incr};
                        op_incr3:  chain = '{incr3};
                        op_jump:   chain = '{jump1, jump2, jump3};
                        op_jumpz:
                        begin
                                if (z)
                                        chain = '{jumpz, jumpzn};
                                else
                                        chain = '{jumpz, jump1, jump2, jump3};
                        end
                        op_jmnz:
                        begin
                                if (z)
                                        chain = '{jmnz, jump1, jump2, jump3};
                                else
                                        chain = '{jmnz, jmnzn};
                        end
                        op_endop:
                        begin
                                repeat (endop_hold)
                                        chain.push_back(endop);
                        end
                        // nop and every unknown opcode.
                        default:   chain = '{nop};
                endcase
                chain.push_front(fetch3);
                chain.push_front(fetch2);
                chain.push_front(fetch1);
        endtask

        task automatic check_outputs(input string tag, input logic [28:0] exp);
                if (write_enable !== exp[28:13])
                begin
                        $display("ERR %s write_enable expected %h got %h", tag, exp[28:13],
                                 write_enable);
                        error_count++;
                end
                if (read_enable !== exp[12:8])
                begin
                        $display("ERR %s read_enable expected %h got %h", tag, exp[12:8],
                                 read_enable);
                        error_count++;
                end
                if (increment !== exp[7:4])
                begin
                        $display("ERR %s increment expected %h got %h", tag, exp[7:4], increment);
                        error_count++;
                end
                if (alu !== exp[3:1])
                begin
                        $display("ERR %s alu expected %h got %h", tag, exp[3:1], alu);
                        error_count++;
                end
                if (finish !== exp[0])
                begin
                        $display("ERR %s finish expected %h got %h", tag, exp[0], finish);
                        error_count++;
                end
        endtask

        task automatic report_test(input string name, input int errors_before);
                test_count++;
                if (error_count == errors_before)
                        $display("test %0d %s: ok", test_count, name);
                else
                begin
                        failed_tests++;
                        $display("test %0d %s: %0d errors", test_count, name,
                                 error_count - errors_before);
                end
        endtask

        task automatic apply_reset(input string name);
                int errors_before;
                errors_before = error_count;
                reset = 1'b1;
                repeat (reset_cycles) @(posedge clk);
                @(negedge clk);
                reset = 1'b0;
                check_outputs(name, 29'd0);
                report_test(name, errors_before);
        endtask

        task automatic run_row(input int i);
                int         errors_before;
                logic [3:0] code;
                errors_before = error_count;
                instruction   = {row_op[i], 4'h0, row_operand[i]};
                zero_flag     = row_z[i];
                code          = decode_operand(row_op[i], row_operand[i]);
                build_chain(row_op[i], row_z[i]);
                // each word shows up one edge after the sequencer reaches its state.
                foreach (chain[k])
                begin
                        @(posedge clk);
                        @(negedge clk);
                        check_outputs($sformatf("%s %s", row_name[i], chain[k].name()),
                                      expected_word(chain[k], code));
                end
                report_test(row_name[i], errors_before);
        endtask

        task automatic add_row(input logic [7:0] op, input logic [3:0] operand, input logic z,
                               input string name);
                row_op.push_back(op);
                row_operand.push_back(operand);
                row_z.push_back(z);
                row_name.push_back(name);
        endtask

        task automatic build_table();
                logic [3:0] operand;
                add_row(op_nop, 4'h0, 1'b0, "nop");
                for (int k = 0; k < 4; k++)
                        add_row(op_add, 4'(k), 1'b0, $sformatf("add %0d", k));
                add_row(op_add, 4'hd, 1'b0, "add upper bits");
                add_row(op_sub, 4'h0, 1'b0, "sub");
                add_row(op_clac, 4'h0, 1'b0, "clac");
                add_row(op_sftr, 4'h0, 1'b0, "sftr");
                add_row(op_sftl, 4'h0, 1'b0, "sftl");
                add_row(op_incac, 4'h0, 1'b0, "incac");
                add_row(op_incr, 4'h0, 1'b0, "incr");
                add_row(op_incr3, 4'h0, 1'b0, "incr3");
                add_row(op_lodac, 4'h0, 1'b0, "lodac");
                add_row(8'hff, 4'h5, 1'b0, "unknown opcode");
                add_row(op_jump, 4'h0, 1'b0, "jump");
                add_row(op_jumpz, 4'h0, 1'b0, "jumpz z low");
                add_row(op_jumpz, 4'h0, 1'b1, "jumpz z high");
                add_row(op_jmnz, 4'h0, 1'b0, "jmnz z low");
                add_row(op_jmnz, 4'h0, 1'b1, "jmnz z high");
                repeat (6)
                begin
                        random_operand(operand);
                        add_row(op_mvac, operand, 1'b0, $sformatf("mvac code %0d", operand));
                        random_operand(operand);
                        add_row(op_movreg, operand, 1'b0, $sformatf("movreg code %0d", operand));
                end
                add_row(op_mvac, 4'hc, 1'b0, "mvac code 12");
                add_row(op_movreg, 4'h0, 1'b0, "movreg code 0");
                add_row(op_endop, 4'h0, 1'b0, "endop");
                add_row(op_nop, 4'h0, 1'b0, "nop after endop");
        endtask

        initial
        begin
                clk          = 1'b0;
                reset        = 1'b1;
                instruction  = 16'h0000;
                zero_flag    = 1'b0;
                lfsr         = 32'h20f4_8168;
                error_count  = 0;
                failed_tests = 0;
                test_count   = 0;
                cycle_limit  = 0;
                build_table();
                cycle_limit = row_op.size() * 12 + 2 * reset_cycles + 50;
                apply_reset("reset");
                for (int i = 0; i < row_op.size(); i++)
                begin
                        if (i > 0 && row_op[i-1] == op_endop)
                                apply_reset("reset after endop");
                        run_row(i);
                end
                $display("tests %0d, failed %0d, errors %0d", test_count, failed_tests,
                         error_count);
                if (error_count == 0)
                        $display("PASS: all tests");
                else
                        $display("FAIL: see errors above");
                $finish;
        end

endmodule

/* source/control_unit.sv */
module control_unit
        import control_pkg::*;
(
        input  logic                   clk,
        input  logic                   reset,
        input  logic [instr_width-1:0] instruction,
        input  logic                   Z,
        output write_enable_t          write_enable,
        output read_sel_t              read_enable,
        output increment_t             increment,
        output alu_op_t                alu,
        output logic                   finish
);

        state_t   entry_state;
        reg_sel_t operand_reg;
        state_t   state;
        reg_sel_t held_operand;

        opcode_decoder u_decoder (
                .instruction (instruction),
                .entry_state (entry_state),
                .operand_reg (operand_reg)
        );

        micro_sequencer u_sequencer (
                .clk          (clk),
                .reset        (reset),
                .Z            (Z),
                .entry_state  (entry_state),
                .operand_reg  (operand_reg),
                .state        (state),
                .held_operand (held_operand)
        );

        control_word_encoder u_encoder (
                .clk          (clk),
                .reset        (reset),
                .state        (state),
                .held_operand (held_operand),
                .write_enable (write_enable),
                .read_enable  (read_enable),
                .increment    (increment),
                .alu          (alu),
                .finish       (finish)
        );

endmodule

/* source/control_word_encoder.sv */
module control_word_encoder
        import control_pkg::*;
(
        input  logic          clk,
        input  logic          reset,
        input  state_t        state,
        input  reg_sel_t      held_operand,
        output write_enable_t write_enable,
        output read_sel_t     read_enable,
        output increment_t    increment,
        output alu_op_t       alu,
        output logic          finish
);

        write_enable_t we_next;
        read_sel_t     rd_next;
        increment_t    inc_next;
        alu_op_t       alu_next;
        logic          finish_next;
        write_enable_t operand_write;
        read_sel_t     operand_read;
        read_sel_t     ac_read;

        // register codes 1 to 11 sit just above the ar bit and the ac read code.
        always_comb
        begin
                if (held_operand == reg_none)
                begin
                        operand_write = we_none;
                        operand_read  = rd_none;
                        ac_read       = rd_none;
                end
                else
                begin
                        operand_write = we_ar << held_operand;
                        operand_read  = read_sel_t'(rd_ac + held_operand);
                        ac_read       = rd_ac;
                end
        end

        always_comb
        begin
                we_next     = we_none;
                rd_next     = rd_none;
                inc_next    = inc_none;
                alu_next    = alu_no_op;
                finish_next = 1'b0;
                case (state)
                        fetch1, lodac1, jump1: rd_next = rd_ins_mem;
                        fetch2, lodac2, jump2:
                        begin
                                we_next = we_ir;
                                rd_next = rd_ins_mem;
                        end
                        fetch3, jumpzn, jmnzn: inc_next = inc_pc;
                        add1:
                        begin
                                rd_next  = operand_read;
                                alu_next = alu_add;
                        end
                        sub1:
                        begin
                                rd_next  = rd_r;
                                alu_next = alu_sub;
                        end
                        clac1: alu_next = alu_zero;
                        sftr1: alu_next = alu_sftr;
                        sftl1: alu_next = alu_sftl;
                        add2, sub2, clac2, sftr2, sftl2: we_next = we_alu_ac;
                        lodac3:
                        begin
                                we_next  = we_ar;
                                rd_next  = rd_ir;
                                inc_next = inc_pc;
                        end
                        lodac4:
                        begin
                                we_next = we_dr;
                                rd_next = rd_data_mem;
                        end
                        lodac5:
                        begin
                                we_next = we_ac;
                                rd_next = rd_dr;
                        end
                        mvac:
                        begin
                                we_next = operand_write;
                                rd_next = ac_read;
                        end
                        movreg:
                        begin
                                rd_next = operand_read;
                                if (held_operand != reg_none)
                                        we_next = we_ac;
                        end
                        jump3:  we_next = we_ir_pc;
                        incac:  inc_next = inc_ac;
                        incr:   inc_next = inc_r;
                        incr3:  inc_next = inc_r3;
                        endop:  finish_next = 1'b1;
                        // nop, jumpz and jmnz keep the inactive word.
                        default:
                        begin
                        end
                endcase
        end

        always_ff @(posedge clk)
        begin
                if (reset)
                begin
                        write_enable <= we_none;
                        read_enable  <= rd_none;
                        increment    <= inc_none;
                        alu          <= alu_no_op;
                        finish       <= 1'b0;
                end
                else
                begin
                        write_enable <= we_next;
                        read_enable  <= rd_next;
                        increment    <= inc_next;
                        alu          <= alu_next;
                        finish       <= finish_next;
                end
        end

        write_onehot: assert property (@(posedge clk) disable iff (reset)
                $onehot0(write_enable))
                else $error("more than one write enable active: %h", write_enable);

        increment_onehot: assert property (@(posedge clk) disable iff (reset)
                $onehot0(increment))
                else $error("more than one increment active: %h", increment);

        finish_quiet: assert property (@(posedge clk) disable iff (reset)
                finish |-> (write_enable == we_none && read_enable == rd_none &&
                            increment == inc_none && alu == alu_no_op))
                else $error("control word active while finish is high");

endmodule

/* source/micro_sequencer.sv */
module micro_sequencer
        import control_pkg::*;
(
        input  logic     clk,
        input  logic     reset,
        input  logic     Z,
        input  state_t   entry_state,
        input  reg_sel_t operand_reg,
        output state_t   state,
        output reg_sel_t held_operand
);

        state_t next_state;

        always_comb
        begin
                case (state)
                        fetch1: next_state = fetch2;
                        fetch2: next_state = fetch3;
                        fetch3: next_state = entry_state;
                        add1:   next_state = add2;
                        sub1:   next_state = sub2;
                        lodac1: next_state = lodac2;
                        lodac2: next_state = lodac3;
                        lodac3: next_state = lodac4;
                        lodac4: next_state = lodac5;
                        clac1:  next_state = clac2;
                        jump1:  next_state = jump2;
                        jump2:  next_state = jump3;
                        sftr1:  next_state = sftr2;
                        sftl1:  next_state = sftl2;
                        jumpz:
                        begin
                                // a zero accumulator skips the target word.
                                if (Z)
                                        next_state = jumpzn;
                                else
                                        next_state = jump1;
                        end
                        jmnz:
                        begin
                                if (Z)
                                        next_state = jump1;
                                else
                                        next_state = jmnzn;
                        end
                        endop:  next_state = endop;
                        // the last state of every other instruction returns to fetch.
                        default: next_state = fetch1;
                endcase
        end

        always_ff @(posedge clk)
        begin
                if (reset)
                        state <= fetch1;
                else
                        state <= next_state;
        end

        // the operand is held through the whole instruction.
        always_ff @(posedge clk)
        begin
                if (state == fetch3)
                        held_operand <= operand_reg;
        end

        state_legal: assert property (@(posedge clk) disable iff (reset)
                state inside {fetch1, fetch2, fetch3, nop, add1, add2, sub1, sub2,
                              lodac1, lodac2, lodac3, lodac4, lodac5, mvac, movreg,
                              clac1, clac2, jump1, jump2, jump3, jumpz, jumpzn,
                              jmnz, jmnzn, incac, incr, incr3, sftr1, sftr2,
                              sftl1, sftl2, endop})
                else $error("micro_sequencer left the defined states: %0d", state);

endmodule

/* source/opcode_decoder.sv */
module opcode_decoder
        import control_pkg::*;
(
        input  logic [instr_width-1:0] instruction,
        output state_t                 entry_state,
        output reg_sel_t               operand_reg
);

        logic [opcode_width-1:0]  opcode;
        logic [operand_width-1:0] operand_field;

        assign opcode        = instruction[instr_width-1 -: opcode_width];
        assign operand_field = instruction[operand_width-1:0];

        always_comb
        begin
                case (opcode)
                        op_nop:    entry_state = nop;
                        op_add:    entry_state = add1;
                        op_sub:    entry_state = sub1;
                        op_lodac:  entry_state = lodac1;
                        op_mvac:   entry_state = mvac;
                        op_movreg: entry_state = movreg;
                        op_clac:   entry_state = clac1;
                        op_jump:   entry_state = jump1;
                        op_jumpz:  entry_state = jumpz;
                        op_jmnz:   entry_state = jmnz;
                        op_incac:  entry_state = incac;
                        op_incr:   entry_state = incr;
                        op_incr3:  entry_state = incr3;
                        op_sftr:   entry_state = sftr1;
                        op_sftl:   entry_state = sftl1;
                        op_endop:  entry_state = endop;
                        // unknown opcodes run as a nop.
                        default:   entry_state = nop;
                endcase
        end

        always_comb
        begin
                operand_reg = reg_none;
                case (opcode)
                        op_add:
                        begin
                                // add only encodes R, R1 and R2 in its two low bits.
                                case (operand_field[1:0])
                                        2'd1:    operand_reg = reg_r;
                                        2'd2:    operand_reg = reg_r1;
                                        2'd3:    operand_reg = reg_r2;
                                        default: operand_reg = reg_none;
                                endcase
                        end
                        op_mvac, op_movreg:
                        begin
                                if (operand_field >= reg_x && operand_field <= reg_dr)
                                begin
                                        operand_reg = reg_sel_t'(operand_field);
                                end
                        end
                        default:
                        begin
                                operand_reg = reg_none;
                        end
                endcase
        end

endmodule

/* source/control_pkg.sv */
package control_pkg;

        localparam int instr_width   = 16;
        localparam int opcode_width  = 8;
        localparam int operand_width = 4;

        // each opcode carries the number of the first micro-state of its instruction.
        typedef enum logic [opcode_width-1:0] {
                op_nop    = 8'd4,
                op_add    = 8'd5,
                op_sub    = 8'd9,
                op_lodac  = 8'd11,
                op_mvac   = 8'd20,
                op_movreg = 8'd21,
                op_clac   = 8'd22,
                op_jump   = 8'd24,
                op_jumpz  = 8'd27,
                op_jmnz   = 8'd29,
                op_incac  = 8'd31,
                op_incr   = 8'd32,
                op_incr3  = 8'd33,
                op_sftr   = 8'd34,
                op_sftl   = 8'd36,
                op_endop  = 8'd40
        } opcode_t;

        typedef enum logic [5:0] {
                fetch1 = 6'd1,
                fetch2 = 6'd2,
                fetch3 = 6'd3,
                nop    = 6'd4,
                add1   = 6'd5,
                add2   = 6'd6,
                sub1   = 6'd9,
                sub2   = 6'd10,
                lodac1 = 6'd11,
                lodac2 = 6'd12,
                lodac3 = 6'd13,
                lodac4 = 6'd14,
                lodac5 = 6'd15,
                mvac   = 6'd20,
                movreg = 6'd21,
                clac1  = 6'd22,
                clac2  = 6'd23,
                jump1  = 6'd24,
                jump2  = 6'd25,
                jump3  = 6'd26,
                jumpz  = 6'd27,
                jumpzn = 6'd28,
                jmnz   = 6'd29,
                jmnzn  = 6'd30,
                incac  = 6'd31,
                incr   = 6'd32,
                incr3  = 6'd33,
                sftr1  = 6'd34,
                sftr2  = 6'd35,
                sftl1  = 6'd36,
                sftl2  = 6'd37,
                endop  = 6'd40
        } state_t;

        typedef enum logic [operand_width-1:0] {
                reg_none = 4'd0,
                reg_x    = 4'd1,
                reg_y    = 4'd2,
                reg_z    = 4'd3,
                reg_stxy = 4'd4,
                reg_styz = 4'd5,
                reg_stxz = 4'd6,
                reg_r    = 4'd7,
                reg_r1   = 4'd8,
                reg_r2   = 4'd9,
                reg_r3   = 4'd10,
                reg_dr   = 4'd11
        } reg_sel_t;

        typedef logic [15:0] write_enable_t;

        localparam write_enable_t we_none   = 16'h0000;
        localparam write_enable_t we_alu_ac = 16'h0001;
        localparam write_enable_t we_ir_pc  = 16'h0002;
        localparam write_enable_t we_ir     = 16'h0004;
        localparam write_enable_t we_ar     = 16'h0008;
        localparam write_enable_t we_dr     = 16'h4000;
        localparam write_enable_t we_ac     = 16'h8000;

        // read codes 7 to 17 follow the register codes, offset from rd_ac.
        typedef enum logic [4:0] {
                rd_none = 5'd0, rd_ins_mem = 5'd1, rd_data_mem = 5'd2, rd_ir = 5'd4,
                rd_ac = 5'd6, rd_x = 5'd7, rd_y = 5'd8, rd_z = 5'd9, rd_stxy = 5'd10,
                rd_styz = 5'd11, rd_stxz = 5'd12, rd_r = 5'd13, rd_r1 = 5'd14,
                rd_r2 = 5'd15, rd_r3 = 5'd16, rd_dr = 5'd17
        } read_sel_t;

        typedef logic [3:0] increment_t;

        localparam increment_t inc_none = 4'b0000;
        localparam increment_t inc_pc   = 4'b0001;
        localparam increment_t inc_ac   = 4'b0010;
        localparam increment_t inc_r    = 4'b0100;
        localparam increment_t inc_r3   = 4'b1000;

        typedef enum logic [2:0] {
                alu_no_op = 3'd0, alu_add = 3'd1, alu_sub = 3'd3,
                alu_sftr = 3'd4, alu_sftl = 3'd5, alu_zero = 3'd6
        } alu_op_t;

endpackage
